// File: compile.f
+incdir+include
+incdir+test
src/x87_pkg.sv
src/x87_decode.sv
src/x87_stack.sv
src/x87_format.sv
src/x87_execute.sv
src/x87_result.sv
src/x87_unit.sv
test/x87_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := x87_unit_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) include/x87_settings.svh test/x87_model.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: test/x87_model.svh
`ifndef X87_MODEL_SVH
`define X87_MODEL_SVH

// One expected output beat per issued command
typedef struct packed {
    logic        st;
    logic [1:0]  size;
    logic [63:0] data;
    logic        wb;
    logic [15:0] wbv;
} beat_t;

fp64_t m_regs [8];
tag_t  m_tags [8];
int    m_top;
word_t m_fcw;
word_t m_fsw;
beat_t exp_q [$];

function automatic void init_state();
    for (int k = 0; k < 8; k++) begin
        m_tags[k] = 2'b11;
    end
    m_top = 0;
    m_fcw = 16'h037F;
    m_fsw = 16'h0000;
endfunction

function automatic void push_entry(fp64_t v);
    m_top = (m_top + 7) & 7;
    m_regs[m_top] = v;
    m_tags[m_top] = 2'b00;
endfunction

function automatic void pop_entry();
    m_tags[m_top] = 2'b11;
    m_top = (m_top + 1) & 7;
endfunction

// float32 to float64
function automatic fp64_t widen(fp32_t v);
    int e;
    e = int'(v[30:23]);
    if (e == 0) begin
        return {v[31], 63'd0};
    end
    if (e == 255) begin
        return 64'd0;
    end
    return {v[31], 11'(e - 127 + 1023), v[22:0], 29'd0};
endfunction

// float64 to float32, truncating
function automatic fp32_t narrow(fp64_t v);
    int e;
    int e32;
    e = int'(v[62:52]);
    e32 = e - 1023 + 127;
    if (e == 0) begin
        return {v[63], 31'd0};
    end
    // Infinity and NaN fall out of range here too
    if (e32 < 1 || e32 > 254) begin
        return 32'd0;
    end
    return {v[63], 8'(e32), v[51:29]};
endfunction

// Condition codes in order C3, C2, C1, C0
function automatic void set_cc(logic [3:0] cc);
    m_fsw[`X87_FSW_BIT_C3] = cc[3];
    m_fsw[`X87_FSW_BIT_C2] = cc[2];
    m_fsw[`X87_FSW_BIT_C1] = cc[1];
    m_fsw[`X87_FSW_BIT_C0] = cc[0];
endfunction

function automatic void misc_effect(int op);
    fp64_t v;
    logic  s;
    logic  all_ones;
    logic  zero_exp;
    logic  frac;
    v = m_regs[m_top];
    s = v[63];
    all_ones = (v[62:52] == 11'h7FF);
    zero_exp = (v[62:52] == 11'h000);
    frac = (v[51:0] != 52'd0);
    if (m_tags[m_top] == 2'b11) begin
        m_fsw[`X87_FSW_BIT_IE] = 1'b1;
        m_fsw[`X87_FSW_BIT_C0] = 1'b1;
        m_fsw[`X87_FSW_BIT_C2] = 1'b1;
        m_fsw[`X87_FSW_BIT_C3] = 1'b1;
    end else if (op == 0) begin
        m_regs[m_top][63] = ~s;
    end else if (op == 1) begin
        m_regs[m_top][63] = 1'b0;
    end else if (op == 2) begin
        if (all_ones && frac) begin
            set_cc(4'b1101);
            m_fsw[`X87_FSW_BIT_IE] = 1'b1;
        end else if (zero_exp && !frac) begin
            set_cc(4'b1000);
        end else begin
            set_cc({3'b000, s});
        end
    end else if (op == 3) begin
        if (all_ones && frac) begin
            set_cc({2'b11, s, 1'b1});
        end else if (all_ones) begin
            set_cc({2'b01, s, 1'b1});
        end else if (zero_exp && !frac) begin
            set_cc({2'b10, s, 1'b0});
        end else if (zero_exp) begin
            set_cc({2'b11, s, 1'b0});
        end else begin
            set_cc({2'b01, s, 1'b0});
        end
    end
endfunction

// Applies one command to the model and queues its expected beat
function automatic void predict_cmd(cmd_e c, int i, fp32_t m32, fp64_t m64);
    beat_t b;
    fp64_t v;
    int    p;
    b = '0;
    p = (m_top + i) & 7;
    case (c)
        CMD_FNINIT: init_state();
        CMD_FLDCW: m_fcw = m32[15:0];
        CMD_FNSTCW: begin
            b.st = 1'b1;
            b.data = {48'd0, m_fcw};
        end
        CMD_FNSTSW_AX: begin
            b.wb = 1'b1;
            b.wbv = m_fsw;
        end
        CMD_FLD_M32: push_entry(widen(m32));
        CMD_FLD_M64: push_entry(m64);
        CMD_FLD_STI: push_entry(m_regs[p]);
        CMD_FSTP_M32: begin
            b.st = 1'b1;
            b.size = 2'd1;
            b.data = {32'd0, narrow(m_regs[m_top])};
            pop_entry();
        end
        CMD_FSTP_M64: begin
            b.st = 1'b1;
            b.size = 2'd2;
            b.data = m_regs[m_top];
            pop_entry();
        end
        CMD_FXCH_STI: begin
            v = m_regs[p];
            m_regs[p] = m_regs[m_top];
            m_regs[m_top] = v;
        end
        CMD_FSTP_STI: begin
            m_regs[p] = m_regs[m_top];
            m_tags[p] = m_tags[m_top];
            pop_entry();
        end
        CMD_MISC: misc_effect(i);
        default: ;
    endcase
    exp_q.push_back(b);
endfunction

`endif

// File: test/x87_unit_tb.sv
`default_nettype none

`include "x87_settings.svh"

module x87_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import x87_pkg::*;

    `include "x87_model.svh"

    // Upper bound on issued commands, used by the watchdog
    localparam int MAX_CMDS = 400;

    logic        clk;
    logic        rst;
    logic        start;
    logic        cmd_valid;
    cmd_e        cmd;
    sti_t        idx;
    fp32_t       mem_rdata32;
    fp64_t       mem_rdata64;
    logic        memstore_valid;
    store_size_e memstore_size;
    fp64_t       memstore_data64;
    logic        busy;
    logic        done;
    logic        wb_valid;
    word_t       wb_value;

    logic [1:0]  acc_hist;
    int          depth;
    fp32_t       f32_cases [12];
    fp64_t       f64_cases [10];
    fp64_t       cls_cases [8];

    x87_unit DUT (
        .clk, .rst, .start, .cmd_valid, .cmd, .idx, .mem_rdata32, .mem_rdata64,
        .memstore_valid, .memstore_size, .memstore_data64,
        .busy, .done, .wb_valid, .wb_value
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "run stopped on the first error");
    endtask

    // Drives one command, sometimes after an idle cycle
    task automatic issue(cmd_e c, int i, fp32_t m32, fp64_t m64);
        if ($urandom % 4 == 0) begin
            @(posedge clk);
            start <= 1'b0;
            cmd_valid <= 1'b0;
        end
        @(posedge clk);
        start <= 1'b1;
        cmd_valid <= 1'b1;
        cmd <= c;
        idx <= sti_t'(i);
        mem_rdata32 <= m32;
        mem_rdata64 <= m64;
        predict_cmd(c, i, m32, m64);
    endtask

    function automatic fp64_t rand64();
        return {$urandom, $urandom};
    endfunction

    // ------------------------------------------------------------------------
    // Compare process
    // ------------------------------------------------------------------------
    initial begin
        beat_t b;
        acc_hist = 2'b00;
        // Outputs are compared from the first edge after reset
        @(negedge rst);
        forever begin
            @(posedge clk);
            assert (done == acc_hist[1])
                else fail_run($sformatf("MISMATCH done: got %h expected %h",
                                        done, acc_hist[1]));
            assert (busy == acc_hist[0])
                else fail_run($sformatf("MISMATCH busy: got %h expected %h",
                                        busy, acc_hist[0]));
            if (done) begin
                if (exp_q.size() == 0) begin
                    fail_run("done pulsed with no command outstanding");
                end
                b = exp_q.pop_front();
                assert (memstore_valid == b.st)
                    else fail_run($sformatf("MISMATCH memstore_valid: got %h expected %h",
                                            memstore_valid, b.st));
                assert (memstore_size == b.size)
                    else fail_run($sformatf("MISMATCH memstore_size: got %h expected %h",
                                            memstore_size, b.size));
                assert (memstore_data64 == b.data)
                    else fail_run($sformatf("MISMATCH memstore_data64: got %h expected %h",
                                            memstore_data64, b.data));
                assert (wb_valid == b.wb)
                    else fail_run($sformatf("MISMATCH wb_valid: got %h expected %h",
                                            wb_valid, b.wb));
                assert (wb_value == b.wbv)
                    else fail_run($sformatf("MISMATCH wb_value: got %h expected %h",
                                            wb_value, b.wbv));
            end else begin
                assert (!memstore_valid && !wb_valid)
                    else fail_run("result strobe seen without done");
            end
            acc_hist[1] = acc_hist[0];
            acc_hist[0] = start && cmd_valid;
        end
    end

    // Watchdog
    initial begin
        #((MAX_CMDS * 4 + 100) * 10);
        fail_run("watchdog expired before all commands completed");
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        int sel;
        int i;
        fp32_t r32;
        void'($urandom(32'h9e07));
        start = 1'b0;
        cmd_valid = 1'b0;
        cmd = CMD_NOP;
        idx = '0;
        mem_rdata32 = '0;
        mem_rdata64 = '0;
        rst = 1'b1;
        init_state();
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Reset values, then again after FNINIT
        issue(CMD_FNSTCW, 0, 0, 0);
        issue(CMD_FNSTSW_AX, 0, 0, 0);
        issue(CMD_FNINIT, 0, 0, 0);
        issue(CMD_FNSTCW, 0, 0, 0);
        issue(CMD_FNSTSW_AX, 0, 0, 0);
        issue(cmd_e'(5'd5), 0, 0, 0);

        repeat (4) begin
            issue(CMD_FLDCW, 0, $urandom, 0);
            issue(CMD_FNSTCW, 0, 0, 0);
        end

        // LIFO order of f64 loads
        issue(CMD_FNINIT, 0, 0, 0);
        repeat (8) issue(CMD_FLD_M64, 0, 0, rand64());
        repeat (8) issue(CMD_FSTP_M64, 0, 0, 0);

        // f32 round trips: zeros, infinity, NaN, denormals, normals
        f32_cases = '{32'h00000000, 32'h80000000, 32'h7F800000, 32'hFFC00001,
                      32'h00012345, 32'h80012345, 32'h3F800000, 32'hC2F6E979,
                      0, 0, 0, 0};
        for (int k = 8; k < 12; k++) begin
            r32 = $urandom;
            if (r32[30:23] == 8'h00 || r32[30:23] == 8'hFF) begin
                r32[30:23] = 8'h80;
            end
            f32_cases[k] = r32;
        end
        foreach (f32_cases[k]) begin
            issue(CMD_FLD_M32, 0, f32_cases[k], 0);
            issue(CMD_FSTP_M32, 0, 0, 0);
        end

        // f64 to f32 range edges
        f64_cases = '{64'h0000000000000000, 64'h8000000000000000, 64'h7FF0000000000000,
                      64'h7E37E43C8800759C, 64'h0010000000000000, 64'h3810000000000000,
                      64'h47EFFFFFE0000000, 64'h47F0000000000000, 64'hC00921FB54442D18,
                      64'h380FFFFFFFFFFFFF};
        foreach (f64_cases[k]) begin
            issue(CMD_FLD_M64, 0, 0, f64_cases[k]);
            issue(CMD_FSTP_M32, 0, 0, 0);
        end

        // Random register moves on a full stack
        issue(CMD_FNINIT, 0, 0, 0);
        repeat (8) issue(CMD_FLD_M64, 0, 0, rand64());
        depth = 8;
        repeat (48) begin
            sel = $urandom % 3;
            if (depth == 0) begin
                issue(CMD_FLD_M64, 0, 0, rand64());
                depth++;
            end else begin
                i = $urandom % depth;
                if (sel == 0 && depth < 8) begin
                    issue(CMD_FLD_STI, i, 0, 0);
                    depth++;
                end else if (sel == 1) begin
                    issue(CMD_FXCH_STI, i, 0, 0);
                end else begin
                    issue(CMD_FSTP_STI, i, 0, 0);
                    depth--;
                end
            end
        end
        repeat (depth) issue(CMD_FSTP_M64, 0, 0, 0);

        // Misc fault on an empty stack
        issue(CMD_FNINIT, 0, 0, 0);
        issue(CMD_MISC, int'(MISC_FXAM), 0, 0);
        issue(CMD_FNSTSW_AX, 0, 0, 0);

        // Sign and classification per value class
        cls_cases = '{64'h0000000000000000, 64'h8000000000000000, 64'h7FF0000000000000,
                      64'hFFF0000000000000, 64'h7FF8000000000000, 64'h0000000000000001,
                      64'hBFF0000000000000, 64'h4008000000000000};
        foreach (cls_cases[k]) begin
            issue(CMD_FNINIT, 0, 0, 0);
            issue(CMD_FLD_M64, 0, 0, cls_cases[k]);
            issue(CMD_MISC, int'(MISC_FTST), 0, 0);
            issue(CMD_FNSTSW_AX, 0, 0, 0);
            issue(CMD_MISC, int'(MISC_FXAM), 0, 0);
            issue(CMD_FNSTSW_AX, 0, 0, 0);
            issue(CMD_MISC, int'(MISC_FCHS), 0, 0);
            issue(CMD_FSTP_M64, 0, 0, 0);
            issue(CMD_FLD_M64, 0, 0, cls_cases[k]);
            issue(CMD_MISC, int'(MISC_FABS), 0, 0);
            issue(CMD_FSTP_M64, 0, 0, 0);
        end

        @(posedge clk);
        start <= 1'b0;
        cmd_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // A few idle edges so a stray done is still caught
        repeat (3) @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/x87_unit.sv
`default_nettype none

module x87_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 cmd_valid,
    input  x87_pkg::cmd_e        cmd,
    input  x87_pkg::sti_t        idx,
    input  x87_pkg::fp32_t       mem_rdata32,
    input  x87_pkg::fp64_t       mem_rdata64,
    output logic                 memstore_valid,
    output x87_pkg::store_size_e memstore_size,
    output x87_pkg::fp64_t       memstore_data64,
    output logic                 busy,
    output logic                 done,
    output logic                 wb_valid,
    output x87_pkg::word_t       wb_value
);
    import x87_pkg::*;

    // Decode to execute
    logic  dec_valid;
    cmd_e  dec_cmd;
    sti_t  dec_idx;
    fp32_t dec_mem32;
    fp64_t dec_mem64;
    logic  push;
    logic  pop;
    logic  needs_st0;

    // Execute and stack
    logic  init;
    logic  wr0;
    fp64_t wr0_data;
    logic  wri;
    fp64_t wri_data;
    tag_t  wri_tag;
    fp64_t st0;
    fp64_t sti;
    tag_t  tag0;
    tag_t  tagi;

    // Format helpers
    fp64_t ld_value;
    fp32_t sp_value;
    cc_t   tst_cc;
    cc_t   xam_cc;

    // Execute to result
    logic        st_req;
    store_size_e st_size;
    fp64_t       st_data;
    logic        wb_req;
    word_t       wb_data;
    logic        cmd_done;

    assign busy = dec_valid;

    x87_decode u_decode (
        .clk, .rst, .start, .cmd_valid, .cmd, .idx, .mem_rdata32, .mem_rdata64,
        .dec_valid, .dec_cmd, .dec_idx, .dec_mem32, .dec_mem64,
        .push, .pop, .needs_st0
    );

    // ST1 has no consumer once arithmetic is gone
    x87_stack u_stack (
        .clk, .rst, .init, .push, .pop, .wr0, .wr0_data,
        .wri, .wri_data, .wri_tag, .idx(dec_idx),
        .st0, .st1(), .sti, .tag0, .tagi
    );

    x87_format u_format (
        .mem32(dec_mem32), .st0, .ld_value, .sp_value, .tst_cc, .xam_cc
    );

    x87_execute u_execute (
        .clk, .rst, .dec_valid, .dec_cmd, .dec_idx, .dec_mem32, .dec_mem64,
        .push, .pop, .needs_st0, .st0, .sti, .tag0, .tagi,
        .ld_value, .sp_value, .tst_cc, .xam_cc,
        .init, .wr0, .wr0_data, .wri, .wri_data, .wri_tag,
        .st_req, .st_size, .st_data, .wb_req, .wb_data, .cmd_done
    );

    x87_result u_result (
        .clk, .rst, .st_req, .st_size, .st_data, .wb_req, .wb_data, .cmd_done,
        .memstore_valid, .memstore_size, .memstore_data64,
        .wb_valid, .wb_value, .done
    );

endmodule

`default_nettype wire

// File: src/x87_result.sv
`default_nettype none

module x87_result (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 st_req,
    input  x87_pkg::store_size_e st_size,
    input  x87_pkg::fp64_t       st_data,
    input  logic                 wb_req,
    input  x87_pkg::word_t       wb_data,
    input  logic                 cmd_done,
    output logic                 memstore_valid,
    output x87_pkg::store_size_e memstore_size,
    output x87_pkg::fp64_t       memstore_data64,
    output logic                 wb_valid,
    output x87_pkg::word_t       wb_value,
    output logic                 done
);
    import x87_pkg::*;

    // One-cycle strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            memstore_valid <= 1'b0;
            wb_valid       <= 1'b0;
            done           <= 1'b0;
        end else begin
            memstore_valid <= st_req;
            wb_valid       <= wb_req;
            done           <= cmd_done;
        end
    end

    // Data outputs read zero between beats
    always_ff @(posedge clk) begin
        memstore_size   <= st_req ? st_size : ST_SIZE_16;
        memstore_data64 <= st_req ? st_data : '0;
        wb_value        <= wb_req ? wb_data : '0;
    end

    a_beat_done: assert property (@(posedge clk) disable iff (rst)
        (wb_valid || memstore_valid) |-> done)
        else $error("result beat without done");

endmodule

`default_nettype wire

// File: src/x87_execute.sv
`default_nettype none

`include "x87_settings.svh"

module x87_execute (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dec_valid,
    input  x87_pkg::cmd_e        dec_cmd,
    input  x87_pkg::sti_t        dec_idx,
    input  x87_pkg::fp32_t       dec_mem32,
    input  x87_pkg::fp64_t       dec_mem64,
    input  logic                 push,
    input  logic                 pop,
    input  logic                 needs_st0,
    input  x87_pkg::fp64_t       st0,
    input  x87_pkg::fp64_t       sti,
    input  x87_pkg::tag_t        tag0,
    input  x87_pkg::tag_t        tagi,
    input  x87_pkg::fp64_t       ld_value,
    input  x87_pkg::fp32_t       sp_value,
    input  x87_pkg::cc_t         tst_cc,
    input  x87_pkg::cc_t         xam_cc,
    output logic                 init,
    output logic                 wr0,
    output x87_pkg::fp64_t       wr0_data,
    output logic                 wri,
    output x87_pkg::fp64_t       wri_data,
    output x87_pkg::tag_t        wri_tag,
    output logic                 st_req,
    output x87_pkg::store_size_e st_size,
    output x87_pkg::fp64_t       st_data,
    output logic                 wb_req,
    output x87_pkg::word_t       wb_data,
    output logic                 cmd_done
);
    import x87_pkg::*;

    word_t fcw;
    word_t fsw;
    word_t fsw_misc;
    fp64_t load_value;
    misc_e misc_op;
    logic  st0_empty;

    // Copies C3, C2, C1 and C0 into a status word
    function automatic word_t apply_cc(word_t w, cc_t cc);
        word_t r;
        r = w;
        r[`X87_FSW_BIT_C3] = cc[3];
        r[`X87_FSW_BIT_C2] = cc[2];
        r[`X87_FSW_BIT_C1] = cc[1];
        r[`X87_FSW_BIT_C0] = cc[0];
        return r;
    endfunction

    assign misc_op   = misc_e'(dec_idx);
    assign st0_empty = needs_st0 && (tag0 == `X87_TAG_EMPTY);
    assign cmd_done  = dec_valid;

    // Value of a push
    always_comb begin
        case (dec_cmd)
            CMD_FLD_M32: load_value = ld_value;
            CMD_FLD_M64: load_value = dec_mem64;
            default:     load_value = sti;
        endcase
    end

    // ------------------------------------------------------------------------
    // Stack updates and result requests
    // ------------------------------------------------------------------------
    always_comb begin
        init     = 1'b0;
        wr0      = 1'b0;
        wr0_data = push ? load_value : st0;
        wri      = 1'b0;
        wri_data = st0;
        // FSTP ST(i) moves the ST0 tag, FXCH keeps the ST(i) tag
        wri_tag  = pop ? tag0 : tagi;
        st_req   = 1'b0;
        st_size  = ST_SIZE_16;
        st_data  = '0;
        wb_req   = 1'b0;
        wb_data  = fsw;
        if (dec_valid) begin
            case (dec_cmd)
                CMD_FNINIT: init = 1'b1;
                CMD_FNSTSW_AX: wb_req = 1'b1;
                CMD_FNSTCW: begin
                    st_req  = 1'b1;
                    st_data = fp64_t'(fcw);
                end
                CMD_FSTP_M32: begin
                    st_req  = 1'b1;
                    st_size = ST_SIZE_32;
                    st_data = fp64_t'(sp_value);
                end
                CMD_FSTP_M64: begin
                    st_req  = 1'b1;
                    st_size = ST_SIZE_64;
                    st_data = st0;
                end
                CMD_FXCH_STI: begin
                    wr0      = 1'b1;
                    wr0_data = sti;
                    wri      = 1'b1;
                end
                CMD_FSTP_STI: wri = 1'b1;
                CMD_MISC: begin
                    if (!st0_empty && misc_op == MISC_FCHS) begin
                        wr0      = 1'b1;
                        wr0_data = {~st0[`X87_REG_W-1], st0[`X87_REG_W-2:0]};
                    end else if (!st0_empty && misc_op == MISC_FABS) begin
                        wr0      = 1'b1;
                        wr0_data = {1'b0, st0[`X87_REG_W-2:0]};
                    end
                end
                default: ;
            endcase
        end
    end

    // Status word after a misc command
    always_comb begin
        fsw_misc = fsw;
        if (st0_empty) begin
            // Stack fault, C1 untouched
            fsw_misc[`X87_FSW_BIT_IE] = 1'b1;
            fsw_misc[`X87_FSW_BIT_C0] = 1'b1;
            fsw_misc[`X87_FSW_BIT_C2] = 1'b1;
            fsw_misc[`X87_FSW_BIT_C3] = 1'b1;
        end else begin
            case (misc_op)
                MISC_FTST: begin
                    fsw_misc = apply_cc(fsw, tst_cc);
                    // C2 only comes back set when unordered
                    if (tst_cc[2]) begin
                        fsw_misc[`X87_FSW_BIT_IE] = 1'b1;
                    end
                end
                MISC_FXAM: fsw_misc = apply_cc(fsw, xam_cc);
                default: ;
            endcase
        end
    end

    // Control and status words
    always_ff @(posedge clk) begin
        if (rst) begin
            fcw <= `X87_FCW_RESET;
            fsw <= '0;
        end else if (dec_valid) begin
            case (dec_cmd)
                CMD_FNINIT: begin
                    fcw <= `X87_FCW_RESET;
                    fsw <= '0;
                end
                CMD_FLDCW: fcw <= dec_mem32[`X87_WORD_W-1:0];
                CMD_MISC:  fsw <= fsw_misc;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/x87_format.sv
`default_nettype none

module x87_format (
    input  x87_pkg::fp32_t mem32,
    input  x87_pkg::fp64_t st0,
    output x87_pkg::fp64_t ld_value,
    output x87_pkg::fp32_t sp_value,
    output x87_pkg::cc_t   tst_cc,
    output x87_pkg::cc_t   xam_cc
);
    // Field views of both operands
    logic        s32;
    logic [7:0]  e32;
    logic [22:0] m32;
    logic        s64;
    logic [10:0] e64;
    logic [51:0] m64;
    logic [10:0] e_rebias;

    logic is_nan;
    logic is_inf;
    logic is_zero;
    logic is_denorm;

    assign {s32, e32, m32} = mem32;
    assign {s64, e64, m64} = st0;

    // Bias difference between binary64 and binary32 is 896
    assign e_rebias = e64 - 11'd896;

    // ------------------------------------------------------------------------
    // float32 to float64
    // ------------------------------------------------------------------------
    always_comb begin
        if (e32 == 8'd0) begin
            ld_value = {s32, 63'd0};
        end else if (e32 == 8'hFF) begin
            ld_value = '0;
        end else begin
            ld_value = {s32, {3'd0, e32} + 11'd896, m32, 29'd0};
        end
    end

    // float64 to float32, mantissa truncated
    always_comb begin
        if (e64 == 11'd0) begin
            sp_value = {s64, 31'd0};
        end else if (e64 < 11'd897 || e64 > 11'd1150) begin
            // Also covers the all-ones exponent
            sp_value = '0;
        end else begin
            sp_value = {s64, e_rebias[7:0], m64[51:29]};
        end
    end

    // ------------------------------------------------------------------------
    // Classification of ST0
    // ------------------------------------------------------------------------
    assign is_nan    = (&e64) && (|m64);
    assign is_inf    = (&e64) && !(|m64);
    assign is_zero   = (e64 == 11'd0) && !(|m64);
    assign is_denorm = (e64 == 11'd0) && (|m64);

    // FTST against +0.0, C1 cleared
    always_comb begin
        if (is_nan) begin
            tst_cc = 4'b1101;
        end else if (is_zero) begin
            tst_cc = 4'b1000;
        end else if (s64) begin
            tst_cc = 4'b0001;
        end else begin
            tst_cc = 4'b0000;
        end
    end

    // FXAM, C1 carries the sign
    always_comb begin
        if (is_nan) begin
            xam_cc = {2'b11, s64, 1'b1};
        end else if (is_inf) begin
            xam_cc = {2'b01, s64, 1'b1};
        end else if (is_zero) begin
            xam_cc = {2'b10, s64, 1'b0};
        end else if (is_denorm) begin
            xam_cc = {2'b11, s64, 1'b0};
        end else begin
            xam_cc = {2'b01, s64, 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: src/x87_stack.sv
`default_nettype none

`include "x87_settings.svh"

module x87_stack (
    input  logic           clk,
    input  logic           rst,
    input  logic           init,
    input  logic           push,
    input  logic           pop,
    input  logic           wr0,
    input  x87_pkg::fp64_t wr0_data,
    input  logic           wri,
    input  x87_pkg::fp64_t wri_data,
    input  x87_pkg::tag_t  wri_tag,
    input  x87_pkg::sti_t  idx,
    output x87_pkg::fp64_t st0,
    output x87_pkg::fp64_t st1,
    output x87_pkg::fp64_t sti,
    output x87_pkg::tag_t  tag0,
    output x87_pkg::tag_t  tagi
);
    import x87_pkg::*;

    fp64_t regs [`X87_DEPTH];
    tag_t  tags [`X87_DEPTH];
    sti_t  top;

    // Physical slots, logical index plus top wraps modulo the depth
    sti_t phys0;
    sti_t phys1;
    sti_t physi;
    sti_t phys_push;

    assign phys0     = top;
    assign phys1     = top + sti_t'(1);
    assign physi     = top + idx;
    assign phys_push = top - sti_t'(1);

    assign st0  = regs[phys0];
    assign st1  = regs[phys1];
    assign sti  = regs[physi];
    assign tag0 = tags[phys0];
    assign tagi = tags[physi];

    // ------------------------------------------------------------------------
    // Tags and top pointer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || init) begin
            top <= '0;
            for (int i = 0; i < `X87_DEPTH; i++) begin
                tags[i] <= `X87_TAG_EMPTY;
            end
        end else begin
            if (wri) begin
                tags[physi] <= wri_tag;
            end
            // A pushed entry is always tagged valid
            if (push) begin
                tags[phys_push] <= 2'b00;
                top             <= phys_push;
            end
            // Pop goes last so FSTP ST(0) leaves the slot empty
            if (pop) begin
                tags[phys0] <= `X87_TAG_EMPTY;
                top         <= phys1;
            end
        end
    end

    // Entry values
    always_ff @(posedge clk) begin
        if (wri) begin
            regs[physi] <= wri_data;
        end
        if (wr0) begin
            regs[phys0] <= wr0_data;
        end
        if (push) begin
            regs[phys_push] <= wr0_data;
        end
    end

    a_push_pop: assert property (@(posedge clk) disable iff (rst) !(push && pop))
        else $error("push and pop in the same cycle");

endmodule

`default_nettype wire

// File: src/x87_decode.sv
`default_nettype none

module x87_decode (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           cmd_valid,
    input  x87_pkg::cmd_e  cmd,
    input  x87_pkg::sti_t  idx,
    input  x87_pkg::fp32_t mem_rdata32,
    input  x87_pkg::fp64_t mem_rdata64,
    output logic           dec_valid,
    output x87_pkg::cmd_e  dec_cmd,
    output x87_pkg::sti_t  dec_idx,
    output x87_pkg::fp32_t dec_mem32,
    output x87_pkg::fp64_t dec_mem64,
    output logic           push,
    output logic           pop,
    output logic           needs_st0
);
    import x87_pkg::*;

    logic accept;
    logic is_load;
    logic is_pop;
    logic uses_st0;

    assign accept = start && cmd_valid;

    // Stack effect of each code
    always_comb begin
        is_load  = 1'b0;
        is_pop   = 1'b0;
        uses_st0 = 1'b0;
        case (cmd)
            CMD_FLD_M32, CMD_FLD_M64, CMD_FLD_STI: begin
                is_load = 1'b1;
            end
            CMD_FSTP_M32, CMD_FSTP_M64, CMD_FSTP_STI: begin
                is_pop   = 1'b1;
                uses_st0 = 1'b1;
            end
            CMD_MISC: begin
                uses_st0 = 1'b1;
            end
            default: ;
        endcase
    end

    // Push and pop leave here already qualified with the accept
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
            push      <= 1'b0;
            pop       <= 1'b0;
        end else begin
            dec_valid <= accept;
            push      <= accept && is_load;
            pop       <= accept && is_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_cmd   <= cmd;
            dec_idx   <= idx;
            dec_mem32 <= mem_rdata32;
            dec_mem64 <= mem_rdata64;
            needs_st0 <= uses_st0;
        end
    end

    a_known_cmd: assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> !$isunknown(dec_cmd))
        else $error("decoded command holds an unknown code");

endmodule

`default_nettype wire

// File: src/x87_pkg.sv
`default_nettype none

`include "x87_settings.svh"

package x87_pkg;

    // Widths that carry a meaning
    typedef logic [`X87_REG_W-1:0]         fp64_t;
    typedef logic [`X87_SP_W-1:0]          fp32_t;
    typedef logic [`X87_WORD_W-1:0]        word_t;
    typedef logic [$clog2(`X87_DEPTH)-1:0] sti_t;
    typedef logic [1:0]                    tag_t;

    // Condition codes packed as {C3, C2, C1, C0}
    typedef logic [3:0]                    cc_t;

    // Command codes, the gaps belong to dropped instructions
    typedef enum logic [4:0] {
        CMD_NOP       = 5'd0,
        CMD_FNSTSW_AX = 5'd1,
        CMD_FNINIT    = 5'd2,
        CMD_FLDCW     = 5'd3,
        CMD_FNSTCW    = 5'd4,
        CMD_FLD_M32   = 5'd6,
        CMD_FLD_M64   = 5'd7,
        CMD_FSTP_M32  = 5'd8,
        CMD_FSTP_M64  = 5'd9,
        CMD_FLD_STI   = 5'd10,
        CMD_FXCH_STI  = 5'd11,
        CMD_FSTP_STI  = 5'd12,
        CMD_MISC      = 5'd31
    } cmd_e;

    // Misc group, selected by idx
    typedef enum logic [2:0] {
        MISC_FCHS = 3'd0,
        MISC_FABS = 3'd1,
        MISC_FTST = 3'd2,
        MISC_FXAM = 3'd3
    } misc_e;

    // Memory store width
    typedef enum logic [1:0] {
        ST_SIZE_16 = 2'd0,
        ST_SIZE_32 = 2'd1,
        ST_SIZE_64 = 2'd2
    } store_size_e;

endpackage

`default_nettype wire

// File: include/x87_settings.svh
`ifndef X87_SETTINGS_SVH
`define X87_SETTINGS_SVH

// Stack geometry and value widths
`define X87_DEPTH      8
`define X87_REG_W      64
`define X87_SP_W       32
`define X87_WORD_W     16

// Control word after reset or FNINIT
`define X87_FCW_RESET  16'h037F

// Status word bit positions
`define X87_FSW_BIT_IE 0
`define X87_FSW_BIT_C0 8
`define X87_FSW_BIT_C1 9
`define X87_FSW_BIT_C2 10
`define X87_FSW_BIT_C3 14

// Empty tag, a valid entry carries 2'b00
`define X87_TAG_EMPTY  2'b11

`endif
